/* verilog.f */
logic/bpu_pkg.sv
logic/bpu_btb.sv
logic/bpu_pht.sv
logic/bpu_ras.sv
logic/core_jmp.sv
logic/branch_unit_top.sv
dv/tb_clkgen.sv
dv/tb_branch_unit.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_branch_unit -o sim_branch_unit -f verilog.f

./obj_dir/sim_branch_unit > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

/* dv/tb_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit;

  import bpu_pkg::*;

  localparam int btb_n   = 64;
  localparam int lht_n   = 16;
  localparam int ras_n   = 8;
  localparam int hw      = 4;
  localparam int btb_iw  = $clog2(btb_n);
  localparam int lht_iw  = $clog2(lht_n);
  localparam int ptr_w   = $clog2(ras_n);
  localparam int num_txn = 400;
  // two cycles per transaction, margin covers reset and directed part
  localparam int timeout_ns = 2 * num_txn * 10 + 2000;

  logic                 clk;
  logic                 rst_n_i;
  logic                 predict_valid_i;
  logic [31:0]          fetch_pc_i;
  logic                 pred_taken_o;
  logic [31:0]          pred_pc_o;
  bpu_target_t          pred_target_type_o;
  logic                 pred_cond_o;
  logic [bpu_cnt_w-1:0] pred_lphr_o;
  logic [hw-1:0]        pred_history_o;
  logic [ptr_w-1:0]     pred_ras_ptr_o;
  logic                 resolve_valid_i;
  logic [31:0]          resolve_pc_i;
  bpu_target_t          resolve_target_type_i;
  logic [3:0]           resolve_cmp_type_i;
  logic [31:0]          resolve_target_i;
  logic [31:0]          resolve_r0_i;
  logic [31:0]          resolve_r1_i;
  logic                 resolve_pred_taken_i;
  logic [31:0]          resolve_pred_pc_i;
  bpu_target_t          resolve_pred_target_type_i;
  logic                 resolve_pred_cond_i;
  logic [bpu_cnt_w-1:0] resolve_pred_lphr_i;
  logic [hw-1:0]        resolve_pred_history_i;
  logic [ptr_w-1:0]     resolve_pred_ras_ptr_i;
  logic                 redirect_o;
  logic [31:0]          redirect_pc_o;

  integer seed;
  int     errors;
  int     checks;

  // pc pool, each pc with a fixed kind and target
  logic [31:0] pool_pc     [8];
  bpu_target_t pool_type   [8];
  logic [31:0] pool_target [8];
  // operand set with equal, sign and edge values
  logic [31:0] opnd        [8];

  // reference state of the tables
  logic                 m_valid  [btb_n];
  logic [31-btb_iw-2:0] m_tag    [btb_n];
  logic [31:0]          m_target [btb_n];
  bpu_target_t          m_type   [btb_n];
  logic                 m_cond   [btb_n];
  logic [hw-1:0]        m_lht    [lht_n];
  logic [bpu_cnt_w-1:0] m_pht    [1 << hw];
  logic [31:0]          m_stack  [ras_n];
  logic [ptr_w-1:0]     m_ptr;

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rst_n_o(rst_n_i)
  );

  branch_unit_top #(
    .btb_entries(btb_n),
    .lht_entries(lht_n),
    .ras_depth  (ras_n),
    .hist_w     (hw)
  ) u_branch_unit_top (.*);

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // tables as they come out of reset
  task automatic clear_model();
    for (int i = 0; i < btb_n; i++) begin
      m_valid[i] = 1'b0;
    end
    for (int i = 0; i < lht_n; i++) begin
      m_lht[i] = '0;
    end
    for (int i = 0; i < (1 << hw); i++) begin
      m_pht[i] = 2'b01;
    end
    for (int i = 0; i < ras_n; i++) begin
      m_stack[i] = '0;
    end
    m_ptr = '0;
  endtask

  // predict cycle, then optionally resolve the same pc with the captured bundle
  task automatic run_txn(input int sel, input logic [3:0] cmp, input logic [31:0] r0,
                         input logic [31:0] r1, input logic do_res);
    logic [31:0]          pc;
    logic [31:0]          tgt;
    bpu_target_t          ty;
    logic [btb_iw-1:0]    bi;
    logic [lht_iw-1:0]    li;
    logic                 hit;
    bpu_target_t          e_type;
    logic                 e_cond;
    logic [hw-1:0]        e_hist;
    logic                 e_taken;
    logic [31:0]          e_pc;
    logic [ptr_w-1:0]     e_ptr;
    logic                 c_taken;
    logic [31:0]          c_pc;
    bpu_target_t          c_type;
    logic                 c_cond;
    logic [bpu_cnt_w-1:0] c_lphr;
    logic [hw-1:0]        c_hist;
    logic [ptr_w-1:0]     c_ptr;
    logic                 lt;
    logic                 eq;
    logic                 gt;
    logic                 tt;
    logic                 tc;
    logic                 tmis;
    logic                 miss;
    logic                 upd;
    logic                 fix;
    logic [ptr_w-1:0]     fp;
    pc  = pool_pc[sel];
    tgt = pool_target[sel];
    ty  = pool_type[sel];
    bi  = pc[btb_iw+1:2];
    li  = pc[lht_iw+1:2];

    @(posedge clk);
    #1;
    predict_valid_i = 1'b1;
    resolve_valid_i = 1'b0;
    fetch_pc_i      = pc;
    #4;
    hit     = m_valid[bi] && (m_tag[bi] == pc[31:btb_iw+2]);
    e_type  = hit ? m_type[bi] : bpu_target_npc;
    e_cond  = hit && m_cond[bi];
    e_hist  = m_lht[li];
    e_taken = hit && (!e_cond || m_pht[e_hist][bpu_cnt_w-1]);
    e_pc    = pc + 32'd4;
    e_ptr   = m_ptr;
    if (e_taken && (e_type == bpu_target_return)) begin
      e_pc  = m_stack[m_ptr - 1'b1];
      e_ptr = m_ptr - 1'b1;
    end else if (e_taken) begin
      e_pc = m_target[bi];
      if (e_type == bpu_target_call) begin
        e_ptr = m_ptr + 1'b1;
      end
    end
    // stale resolve fields must not redirect
    compare_value("redirect_o", 32'(redirect_o), 32'd0);
    compare_value("pred_taken_o", 32'(pred_taken_o), 32'(e_taken));
    compare_value("pred_pc_o", pred_pc_o, e_pc);
    compare_value("pred_target_type_o", 32'(pred_target_type_o), 32'(e_type));
    compare_value("pred_cond_o", 32'(pred_cond_o), 32'(e_cond));
    compare_value("pred_lphr_o", 32'(pred_lphr_o), 32'(m_pht[e_hist]));
    compare_value("pred_history_o", 32'(pred_history_o), 32'(e_hist));
    compare_value("pred_ras_ptr_o", 32'(pred_ras_ptr_o), 32'(e_ptr));
    c_taken = pred_taken_o;
    c_pc    = pred_pc_o;
    c_type  = pred_target_type_o;
    c_cond  = pred_cond_o;
    c_lphr  = pred_lphr_o;
    c_hist  = pred_history_o;
    c_ptr   = pred_ras_ptr_o;
    // speculative ras move at the coming edge
    if (e_taken && (e_type == bpu_target_call)) begin
      m_stack[m_ptr] = pc + 32'd4;
      m_ptr          = m_ptr + 1'b1;
    end else if (e_taken && (e_type == bpu_target_return)) begin
      m_ptr = m_ptr - 1'b1;
    end

    if (do_res) begin
      @(posedge clk);
      #1;
      predict_valid_i            = 1'b0;
      resolve_valid_i            = 1'b1;
      resolve_pc_i               = pc;
      resolve_target_type_i      = ty;
      resolve_cmp_type_i         = cmp;
      resolve_target_i           = tgt;
      resolve_r0_i               = r0;
      resolve_r1_i               = r1;
      resolve_pred_taken_i       = c_taken;
      resolve_pred_pc_i          = c_pc;
      resolve_pred_target_type_i = c_type;
      resolve_pred_cond_i        = c_cond;
      resolve_pred_lphr_i        = c_lphr;
      resolve_pred_history_i     = c_hist;
      resolve_pred_ras_ptr_i     = c_ptr;
      #4;
      // less-than means r1 below r0
      if (cmp[0]) begin
        lt = $signed(r1) < $signed(r0);
        gt = $signed(r1) > $signed(r0);
      end else begin
        lt = r1 < r0;
        gt = r1 > r0;
      end
      eq   = r1 == r0;
      tt   = (cmp[3] && lt) || (cmp[2] && eq) || (cmp[1] && gt);
      tc   = (cmp[3:1] != 3'b000) && (cmp[3:1] != 3'b111);
      tmis = ty != c_type;
      miss = (tt || c_taken) && ((c_pc != tgt) || (c_taken != tt));
      compare_value("redirect_o", 32'(redirect_o), 32'(miss));
      compare_value("redirect_pc_o", redirect_pc_o, tt ? tgt : pc + 32'd4);
      upd = (ty != bpu_target_npc) || tmis || miss;
      if (upd && (ty != bpu_target_npc)) begin
        m_valid[bi]  = 1'b1;
        m_tag[bi]    = pc[31:btb_iw+2];
        m_target[bi] = tgt;
        m_type[bi]   = ty;
        m_cond[bi]   = tc;
      end else if (upd && m_valid[bi] && (m_tag[bi] == pc[31:btb_iw+2])) begin
        m_valid[bi] = 1'b0;
      end
      // counter picked by the carried history
      if (tc) begin
        if (tt && (m_pht[c_hist] != 2'b11)) begin
          m_pht[c_hist] = m_pht[c_hist] + 1'b1;
        end else if (!tt && (m_pht[c_hist] != 2'b00)) begin
          m_pht[c_hist] = m_pht[c_hist] - 1'b1;
        end
        m_lht[li] = {m_lht[li][hw-2:0], tt};
      end
      fp  = c_ptr;
      fix = miss;
      if (tmis && (ty == bpu_target_call)) begin
        fp  = c_ptr + 1'b1;
        fix = 1'b1;
      end else if (tmis && (ty == bpu_target_return)) begin
        fp  = c_ptr - 1'b1;
        fix = 1'b1;
      end
      if (fix) begin
        m_ptr = fp;
        if (ty == bpu_target_call) begin
          m_stack[fp - 1'b1] = pc + 32'd4;
        end
      end
    end
  endtask

  initial begin
    int          sel;
    logic [3:0]  cmp;
    logic [31:0] r0;
    logic [31:0] r1;
    seed   = 81140;
    errors = 0;
    checks = 0;
    predict_valid_i            = 1'b0;
    fetch_pc_i                 = '0;
    resolve_valid_i            = 1'b0;
    resolve_pc_i               = '0;
    resolve_target_type_i      = bpu_target_npc;
    resolve_cmp_type_i         = '0;
    resolve_target_i           = '0;
    resolve_r0_i               = '0;
    resolve_r1_i               = '0;
    resolve_pred_taken_i       = 1'b0;
    resolve_pred_pc_i          = '0;
    resolve_pred_target_type_i = bpu_target_npc;
    resolve_pred_cond_i        = 1'b0;
    resolve_pred_lphr_i        = '0;
    resolve_pred_history_i     = '0;
    resolve_pred_ras_ptr_i     = '0;
    // pcs 0, 4 and 6 share btb slot 0 with different tags
    pool_pc = '{32'h0000_1000, 32'h0000_1010, 32'h0000_2024, 32'h0000_3008,
                32'h0000_1100, 32'h0000_4040, 32'h0001_1000, 32'h0000_5034};
    pool_type = '{bpu_target_imm, bpu_target_imm, bpu_target_call, bpu_target_return,
                  bpu_target_npc, bpu_target_imm, bpu_target_imm, bpu_target_call};
    // return at 3 goes back behind the call at 2
    pool_target = '{32'h0000_1400, 32'h0000_0f00, 32'h0000_3000, 32'h0000_2028,
                    32'h0000_1200, 32'h0000_4000, 32'h0001_1800, 32'h0000_6000};
    opnd = '{32'h0000_0000, 32'h0000_0001, 32'h0000_0007, 32'h7fff_ffff,
             32'h8000_0000, 32'hffff_ffff, 32'hffff_fff9, 32'h0000_0007};
    clear_model();
    @(posedge rst_n_i);

    // fresh tables, nothing taken
    for (int i = 0; i < 8; i++) begin
      run_txn(i, 4'd0, 32'd0, 32'd0, 1'b0);
      compare_value("pred_taken_o", 32'(pred_taken_o), 32'd0);
      compare_value("pred_pc_o", pred_pc_o, pool_pc[i] + 32'd4);
    end

    // equal-only compare, always taken, trains pc 0 up to taken
    repeat (8) run_txn(0, 4'b0100, 32'd7, 32'd7, 1'b1);
    run_txn(0, 4'd0, 32'd0, 32'd0, 1'b0);
    compare_value("pred_taken_o", 32'(pred_taken_o), 32'd1);
    compare_value("pred_pc_o", pred_pc_o, pool_target[0]);

    // first round repairs the ras, later rounds predict the return
    repeat (2) begin
      run_txn(2, 4'b1110, 32'd0, 32'd0, 1'b1);
      run_txn(3, 4'b1110, 32'd0, 32'd0, 1'b1);
    end
    run_txn(2, 4'b1110, 32'd0, 32'd0, 1'b1);
    run_txn(3, 4'b1110, 32'd0, 32'd0, 1'b0);
    compare_value("pred_pc_o", pred_pc_o, pool_pc[2] + 32'd4);

    for (int n = 0; n < num_txn; n++) begin
      sel = $random(seed) & 7;
      cmp = 4'($random(seed));
      r0  = opnd[3'($random(seed))];
      r1  = opnd[3'($random(seed))];
      run_txn(sel, cmp, r0, r1, 1'b1);
    end

    @(posedge clk);
    #1;
    predict_valid_i = 1'b0;
    resolve_valid_i = 1'b0;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // release just after the last held edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* logic/branch_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit_top #(
  parameter int btb_entries = bpu_pkg::default_btb_entries,
  parameter int lht_entries = bpu_pkg::default_lht_entries,
  parameter int ras_depth   = bpu_pkg::default_ras_depth,
  parameter int hist_w      = bpu_pkg::bpu_hist_w
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          predict_valid_i,
  input  logic [31:0]                   fetch_pc_i,
  output logic                          pred_taken_o,
  output logic [31:0]                   pred_pc_o,
  output bpu_pkg::bpu_target_t          pred_target_type_o,
  output logic                          pred_cond_o,
  output logic [bpu_pkg::bpu_cnt_w-1:0] pred_lphr_o,
  output logic [hist_w-1:0]             pred_history_o,
  output logic [$clog2(ras_depth)-1:0]  pred_ras_ptr_o,
  input  logic                          resolve_valid_i,
  input  logic [31:0]                   resolve_pc_i,
  input  bpu_pkg::bpu_target_t          resolve_target_type_i,
  input  logic [3:0]                    resolve_cmp_type_i,
  input  logic [31:0]                   resolve_target_i,
  input  logic [31:0]                   resolve_r0_i,
  input  logic [31:0]                   resolve_r1_i,
  input  logic                          resolve_pred_taken_i,
  input  logic [31:0]                   resolve_pred_pc_i,
  input  bpu_pkg::bpu_target_t          resolve_pred_target_type_i,
  input  logic                          resolve_pred_cond_i,
  input  logic [bpu_pkg::bpu_cnt_w-1:0] resolve_pred_lphr_i,
  input  logic [hist_w-1:0]             resolve_pred_history_i,
  input  logic [$clog2(ras_depth)-1:0]  resolve_pred_ras_ptr_i,
  output logic                          redirect_o,
  output logic [31:0]                   redirect_pc_o
);

  import bpu_pkg::*;

  localparam int ras_ptr_w = $clog2(ras_depth);

  logic                 btb_hit;
  logic [31:0]          btb_target;
  bpu_target_t          btb_type;
  logic                 btb_cond;
  logic [31:0]          ras_top;
  logic [ras_ptr_w-1:0] ras_ptr;
  logic                 ras_push;
  logic                 ras_pop;
  logic                 miss;
  logic                 need_update;
  logic                 true_taken;
  logic                 true_cond;
  logic [hist_w-1:0]    corr_history;
  logic [ras_ptr_w-1:0] corr_ras_ptr;
  logic                 ras_fix;

  // unconditional hits always jump, conditional ones ask the counter
  assign pred_taken_o       = btb_hit && (!btb_cond || pred_lphr_o[bpu_cnt_w-1]);
  assign pred_target_type_o = btb_type;
  assign pred_cond_o        = btb_cond;

  always_comb begin
    pred_pc_o = fetch_pc_i + 32'd4;
    if (pred_taken_o && (btb_type == bpu_target_return)) begin
      pred_pc_o = ras_top;
    end else if (pred_taken_o) begin
      pred_pc_o = btb_target;
    end
  end

  assign ras_push = predict_valid_i && pred_taken_o && (btb_type == bpu_target_call);
  assign ras_pop  = predict_valid_i && pred_taken_o && (btb_type == bpu_target_return);

  // carried pointer is the one after this fetch's own push or pop
  always_comb begin
    pred_ras_ptr_o = ras_ptr;
    if (pred_taken_o && (btb_type == bpu_target_call)) begin
      pred_ras_ptr_o = ras_ptr + 1'b1;
    end else if (pred_taken_o && (btb_type == bpu_target_return)) begin
      pred_ras_ptr_o = ras_ptr - 1'b1;
    end
  end

  bpu_btb #(
    .btb_entries(btb_entries)
  ) u_bpu_btb (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .lookup_pc_i      (fetch_pc_i),
    .hit_o            (btb_hit),
    .target_o         (btb_target),
    .target_type_o    (btb_type),
    .cond_o           (btb_cond),
    .upd_i            (need_update),
    .upd_pc_i         (resolve_pc_i),
    .upd_target_i     (resolve_target_i),
    .upd_target_type_i(resolve_target_type_i),
    .upd_cond_i       (true_cond)
  );

  // only conditional branches train direction
  bpu_pht #(
    .lht_entries(lht_entries),
    .hist_w     (hist_w)
  ) u_bpu_pht (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .lookup_pc_i  (fetch_pc_i),
    .history_o    (pred_history_o),
    .lphr_o       (pred_lphr_o),
    .upd_i        (resolve_valid_i && true_cond),
    .upd_pc_i     (resolve_pc_i),
    .upd_history_i(corr_history),
    .upd_taken_i  (true_taken)
  );

  bpu_ras #(
    .ras_depth(ras_depth)
  ) u_bpu_ras (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .push_i     (ras_push),
    .pop_i      (ras_pop),
    .push_addr_i(fetch_pc_i + 32'd4),
    .top_o      (ras_top),
    .ptr_o      (ras_ptr),
    .fix_i      (miss || ras_fix),
    .fix_ptr_i  (corr_ras_ptr),
    .fix_call_i (resolve_valid_i && (resolve_target_type_i == bpu_target_call)),
    .fix_addr_i (resolve_pc_i + 32'd4)
  );

  core_jmp #(
    .hist_w   (hist_w),
    .ras_depth(ras_depth)
  ) u_core_jmp (
    .valid_i           (resolve_valid_i),
    .target_type_i     (resolve_target_type_i),
    .cmp_type_i        (resolve_cmp_type_i),
    .pc_i              (resolve_pc_i),
    .target_i          (resolve_target_i),
    .r0_i              (resolve_r0_i),
    .r1_i              (resolve_r1_i),
    .pred_taken_i      (resolve_pred_taken_i),
    .pred_pc_i         (resolve_pred_pc_i),
    .pred_target_type_i(resolve_pred_target_type_i),
    .pred_cond_i       (resolve_pred_cond_i),
    .pred_lphr_i       (resolve_pred_lphr_i),
    .pred_history_i    (resolve_pred_history_i),
    .pred_ras_ptr_i    (resolve_pred_ras_ptr_i),
    .jmp_o             (redirect_o),
    .target_o          (redirect_pc_o),
    .miss_o            (miss),
    .need_update_o     (need_update),
    .true_taken_o      (true_taken),
    .true_cond_o       (true_cond),
    .history_o         (corr_history),
    .ras_ptr_o         (corr_ras_ptr),
    .ras_fix_o         (ras_fix)
  );

endmodule

`default_nettype wire

/* logic/core_jmp.sv */
`timescale 1ns/1ps
`default_nettype none

module core_jmp #(
  parameter int hist_w    = bpu_pkg::bpu_hist_w,
  parameter int ras_depth = bpu_pkg::default_ras_depth
) (
  input  logic                          valid_i,
  input  bpu_pkg::bpu_target_t          target_type_i,
  input  logic [3:0]                    cmp_type_i,
  input  logic [31:0]                   pc_i,
  input  logic [31:0]                   target_i,
  input  logic [31:0]                   r0_i,
  input  logic [31:0]                   r1_i,
  input  logic                          pred_taken_i,
  input  logic [31:0]                   pred_pc_i,
  input  bpu_pkg::bpu_target_t          pred_target_type_i,
  input  logic                          pred_cond_i,
  input  logic [bpu_pkg::bpu_cnt_w-1:0] pred_lphr_i,
  input  logic [hist_w-1:0]             pred_history_i,
  input  logic [$clog2(ras_depth)-1:0]  pred_ras_ptr_i,
  output logic                          jmp_o,
  output logic [31:0]                   target_o,
  output logic                          miss_o,
  output logic                          need_update_o,
  output logic                          true_taken_o,
  output logic                          true_cond_o,
  output logic [hist_w-1:0]             history_o,
  output logic [$clog2(ras_depth)-1:0]  ras_ptr_o,
  output logic                          ras_fix_o
);

  import bpu_pkg::*;

  logic [32:0] r0_ext;
  logic [32:0] r1_ext;
  logic [3:1]  cmp_res;
  logic        true_taken;
  logic        pred_dir;
  logic        type_miss;
  logic        miss;

  // extra top bit makes one unsigned compare serve both modes
  // signed: negatives get 0, non-negatives get 1
  assign r0_ext = {~r0_i[31] & cmp_type_i[0], r0_i};
  assign r1_ext = {~r1_i[31] & cmp_type_i[0], r1_i};

  assign cmp_res[3] = r1_ext < r0_ext;
  assign cmp_res[2] = r1_ext == r0_ext;
  assign cmp_res[1] = r1_ext > r0_ext;

  assign true_taken = |(cmp_res & cmp_type_i[3:1]);
  // empty mask never jumps, full mask always does
  assign true_cond_o = (|cmp_type_i[3:1]) && !(&cmp_type_i[3:1]);

  // conditional hits got their direction from the carried counter
  assign pred_dir  = pred_cond_i ? pred_lphr_i[bpu_cnt_w-1] : pred_taken_i;
  assign type_miss = target_type_i != pred_target_type_i;

  // both not taken is never a miss, whatever the predicted pc
  always_comb begin
    miss = 1'b0;
    if (valid_i && (true_taken || pred_dir)) begin
      miss = (pred_pc_i != target_i) || (pred_dir != true_taken);
    end
  end

  assign jmp_o    = miss;
  assign miss_o   = miss;
  assign target_o = true_taken ? target_i : (pc_i + 32'd4);

  assign need_update_o = (valid_i && ((|target_type_i) || type_miss)) || miss;
  assign true_taken_o  = true_taken;
  assign history_o     = pred_history_i;

  // fetch missed a call or return, so redo its push or pop
  always_comb begin
    ras_ptr_o = pred_ras_ptr_i;
    ras_fix_o = 1'b0;
    if (valid_i && type_miss && (target_type_i == bpu_target_call)) begin
      ras_ptr_o = pred_ras_ptr_i + 1'b1;
      ras_fix_o = 1'b1;
    end else if (valid_i && type_miss && (target_type_i == bpu_target_return)) begin
      ras_ptr_o = pred_ras_ptr_i - 1'b1;
      ras_fix_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/bpu_ras.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_ras #(
  parameter int ras_depth = bpu_pkg::default_ras_depth
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         push_i,
  input  logic                         pop_i,
  input  logic [31:0]                  push_addr_i,
  output logic [31:0]                  top_o,
  output logic [$clog2(ras_depth)-1:0] ptr_o,
  input  logic                         fix_i,
  input  logic [$clog2(ras_depth)-1:0] fix_ptr_i,
  input  logic                         fix_call_i,
  input  logic [31:0]                  fix_addr_i
);

  localparam int ptr_w = $clog2(ras_depth);

  logic [31:0]      stack_q [ras_depth];
  logic [ptr_w-1:0] ptr_q;
  logic [ptr_w-1:0] top_idx;
  logic [ptr_w-1:0] fix_slot;

  // pointer names the next free slot, top is one below
  // power of two depth, so plain overflow wraps it
  assign top_idx  = ptr_q - 1'b1;
  assign fix_slot = fix_ptr_i - 1'b1;
  assign top_o    = stack_q[top_idx];
  assign ptr_o    = ptr_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
      for (int i = 0; i < ras_depth; i++) begin
        stack_q[i] <= '0;
      end
    end else if (fix_i) begin
      // repair from execute beats any fetch push or pop
      ptr_q <= fix_ptr_i;
      if (fix_call_i) begin
        stack_q[fix_slot] <= fix_addr_i;
      end
    end else if (push_i) begin
      stack_q[ptr_q] <= push_addr_i;
      ptr_q          <= ptr_q + 1'b1;
    end else if (pop_i) begin
      ptr_q <= top_idx;
    end
  end

endmodule

`default_nettype wire

/* logic/bpu_pht.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_pht #(
  parameter int lht_entries = bpu_pkg::default_lht_entries,
  parameter int hist_w      = bpu_pkg::bpu_hist_w
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [31:0]                   lookup_pc_i,
  output logic [hist_w-1:0]             history_o,
  output logic [bpu_pkg::bpu_cnt_w-1:0] lphr_o,
  input  logic                          upd_i,
  input  logic [31:0]                   upd_pc_i,
  input  logic [hist_w-1:0]             upd_history_i,
  input  logic                          upd_taken_i
);

  import bpu_pkg::*;

  localparam int lht_idx_w   = $clog2(lht_entries);
  localparam int pht_entries = 1 << hist_w;
  // counters start weakly not taken
  localparam logic [bpu_cnt_w-1:0] cnt_init = bpu_cnt_w'(1);

  logic [hist_w-1:0]    lht_q [lht_entries];
  logic [bpu_cnt_w-1:0] pht_q [pht_entries];

  logic [lht_idx_w-1:0] rd_idx;
  logic [lht_idx_w-1:0] wr_idx;
  logic [bpu_cnt_w-1:0] cnt_cur;
  logic [bpu_cnt_w-1:0] cnt_next;

  // two-level lookup, pc picks history, history picks counter
  assign rd_idx    = lookup_pc_i[lht_idx_w+1:2];
  assign history_o = lht_q[rd_idx];
  assign lphr_o    = pht_q[history_o];

  // training uses the history seen at predict time
  assign wr_idx  = upd_pc_i[lht_idx_w+1:2];
  assign cnt_cur = pht_q[upd_history_i];

  // one step toward the outcome, clamp at both ends
  always_comb begin
    cnt_next = cnt_cur;
    if (upd_taken_i && (cnt_cur != '1)) begin
      cnt_next = cnt_cur + 1'b1;
    end else if (!upd_taken_i && (cnt_cur != '0)) begin
      cnt_next = cnt_cur - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < pht_entries; i++) begin
        pht_q[i] <= cnt_init;
      end
    end else if (upd_i) begin
      pht_q[upd_history_i] <= cnt_next;
    end
  end

  // newest outcome enters at bit 0
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < lht_entries; i++) begin
        lht_q[i] <= '0;
      end
    end else if (upd_i) begin
      lht_q[wr_idx] <= {lht_q[wr_idx][hist_w-2:0], upd_taken_i};
    end
  end

endmodule

`default_nettype wire

/* logic/bpu_btb.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_btb #(
  parameter int btb_entries = bpu_pkg::default_btb_entries
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [31:0]          lookup_pc_i,
  output logic                 hit_o,
  output logic [31:0]          target_o,
  output bpu_pkg::bpu_target_t target_type_o,
  output logic                 cond_o,
  input  logic                 upd_i,
  input  logic [31:0]          upd_pc_i,
  input  logic [31:0]          upd_target_i,
  input  bpu_pkg::bpu_target_t upd_target_type_i,
  input  logic                 upd_cond_i
);

  import bpu_pkg::*;

  // index sits just above the word offset, tag is the rest
  localparam int idx_w = $clog2(btb_entries);
  localparam int tag_w = 32 - idx_w - 2;

  logic [btb_entries-1:0] valid_q;
  logic [btb_entries-1:0] cond_q;
  logic [tag_w-1:0]       tag_q    [btb_entries];
  logic [31:0]            target_q [btb_entries];
  bpu_target_t            type_q   [btb_entries];

  logic [idx_w-1:0] rd_idx;
  logic [tag_w-1:0] rd_tag;
  logic [idx_w-1:0] wr_idx;
  logic [tag_w-1:0] wr_tag;
  logic             wr_match;
  logic             wr_fill;

  // lookup side, purely combinational
  assign rd_idx = lookup_pc_i[idx_w+1:2];
  assign rd_tag = lookup_pc_i[31:idx_w+2];

  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target_o = target_q[rd_idx];
  // a miss looks like a non-branch to fetch
  assign target_type_o = hit_o ? type_q[rd_idx] : bpu_target_npc;
  assign cond_o        = hit_o && cond_q[rd_idx];

  // correction side
  assign wr_idx   = upd_pc_i[idx_w+1:2];
  assign wr_tag   = upd_pc_i[31:idx_w+2];
  assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);
  // any real branch type allocates or overwrites the slot
  assign wr_fill  = upd_i && (upd_target_type_i != bpu_target_npc);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (wr_fill) begin
      valid_q[wr_idx] <= 1'b1;
    end else if (upd_i && wr_match) begin
      // resolved as non-branch, drop only our own entry
      valid_q[wr_idx] <= 1'b0;
    end
  end

  // payload fields, no reset needed behind valid
  always_ff @(posedge clk) begin
    if (wr_fill) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= upd_target_i;
      type_q[wr_idx]   <= upd_target_type_i;
      cond_q[wr_idx]   <= upd_cond_i;
    end
  end

endmodule

`default_nettype wire

/* logic/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

  // kind of control transfer
  // held per btb entry and carried with each resolve
  typedef logic [1:0] bpu_target_t;

  // not a branch, plain pc+4
  localparam bpu_target_t bpu_target_npc = 2'd0;

  // call, pushes the return address
  localparam bpu_target_t bpu_target_call = 2'd1;

  // return, target comes from the ras
  localparam bpu_target_t bpu_target_return = 2'd2;

  // direct branch or jump with a known target
  localparam bpu_target_t bpu_target_imm = 2'd3;

  // local history length per pc slot
  // also sets the counter table depth (2**hist)
  localparam int bpu_hist_w = 4;

  // saturating direction counter, msb is the taken guess
  // same width as the lphr value carried with a prediction
  localparam int bpu_cnt_w = 2;

  // table sizes used by the top as defaults
  // all must be powers of two
  localparam int default_btb_entries = 64;

  localparam int default_lht_entries = 16;

  // ras pointer wraps at this depth
  localparam int default_ras_depth = 8;

endpackage

`default_nettype wire
